// ==== verilog.f ====
+incdir+include
verilog/videoPkg.sv
verilog/videoTiming.sv
verilog/vramController.sv
verilog/fixFetch.sv
verilog/cpuVramPort.sv
verilog/videoSubsystem.sv
tests/tb_videoSubsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_videoSubsystem
FILELIST := verilog.f
BUILD_DIR := obj_dir
SIM_FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_videoSubsystem.sv ====
`timescale 1ns/1ns

`include "video_defs.svh"

module tb_videoSubsystem;

	import videoPkg::*;

	// Operation kinds in the table
	localparam int KIND_LOAD = 0;
	localparam int KIND_WRITE = 1;
	localparam int KIND_READ = 2;
	localparam int KIND_FILL = 3;
	localparam int KIND_LIVE = 4;
	localparam int OP_COUNT = 56;
	localparam longint FRAME_CYCLES = 264 * 1536;
	localparam longint WATCHDOG_CYCLES = 3 * FRAME_CYCLES + OP_COUNT * 64;

	logic CLK_24M = 1'b0;
	logic nRESETP;
	cpuReg_t cpuSel;
	vramData_t cpuWrData;
	logic cpuWr;
	logic cpuRd;
	vramData_t cpuRdData;
	logic cpuBusy;
	hCount_t hCount;
	vCount_t vCount;
	logic nHSync;
	logic nHBlank;
	logic vBlank;
	logic nVSync;
	logic nBnkb;
	vramData_t fixCode;
	logic fixStrobe;

	// Operation table and RAM mirror
	int opKind [OP_COUNT];
	vramAddr_t opAddr [OP_COUNT];
	vramData_t opData [OP_COUNT];
	vramData_t opExp [OP_COUNT];
	int opCount = 0;
	vramData_t model [0:2047];
	logic [31:0] rngState = 32'h2bde_52fb;

	int checks = 0;
	int errors = 0;
	int syncFails = 0;
	int frameFails = 0;
	int fixFails = 0;
	int syncLen;
	int blankLen;
	int syncLines = 0;
	int blankLines = 0;
	int linesSeen = 0;
	int fixCol = 0;
	vCount_t expLine;
	vCount_t fixLine;
	hCount_t expCount;
	bit fixVisible = 1'b0;
	bit armFrame = 1'b0;
	bit frameCheck = 1'b0;
	bit frameDone = 1'b0;

	videoSubsystem videoSubsystem_inst (
		.CLK_24M(CLK_24M), .nRESETP(nRESETP),
		.cpuSel(cpuSel), .cpuWrData(cpuWrData), .cpuWr(cpuWr), .cpuRd(cpuRd),
		.cpuRdData(cpuRdData), .cpuBusy(cpuBusy),
		.hCount(hCount), .vCount(vCount), .nHSync(nHSync), .nHBlank(nHBlank),
		.vBlank(vBlank), .nVSync(nVSync), .nBnkb(nBnkb),
		.fixCode(fixCode), .fixStrobe(fixStrobe)
	);

	// 40 ns master clock
	always #20 CLK_24M = ~CLK_24M;

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic vramData_t randomWord();
		rngState = xorshift32(rngState);
		return rngState[15:0];
	endfunction

	task automatic checkWord(string name, vramData_t got, vramData_t exp, inout int fails);
		checks++;
		if (got !== exp)
		begin
			errors++;
			fails++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkLine(string name, vCount_t got, vCount_t exp, inout int fails);
		checks++;
		if (got !== exp)
		begin
			errors++;
			fails++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkCount(string name, hCount_t got, hCount_t exp, inout int fails);
		checks++;
		if (got !== exp)
		begin
			errors++;
			fails++;
			$display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkLevel(string name, logic got, logic exp, inout int fails);
		checks++;
		if (got !== exp)
		begin
			errors++;
			fails++;
			$display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic addOp(int kind, vramAddr_t addr, vramData_t data, vramData_t exp);
		opKind[opCount] = kind;
		opAddr[opCount] = addr;
		opData[opCount] = data;
		opExp[opCount] = exp;
		opCount++;
	endtask

	task automatic buildTable();
		vramData_t first [6];
		vramData_t second [4];
		// Block outside the map columns, bits 5..0 above 39
		addOp(KIND_LOAD, 11'h030, '0, '0);
		for (int k = 0; k < 6; k++)
		begin
			first[k] = randomWord();
			addOp(KIND_WRITE, 11'h030 + vramAddr_t'(k), first[k], first[k]);
		end
		for (int k = 0; k < 6; k++)
			addOp(KIND_READ, 11'h030 + vramAddr_t'(k), '0, first[k]);
		// All 32 tile rows of the fix map
		for (int r = 0; r < 32; r++)
			addOp(KIND_FILL, `FIX_BASE + vramAddr_t'(r * 64), '0, '0);
		// Rest runs during active display
		addOp(KIND_LIVE, '0, '0, '0);
		addOp(KIND_LOAD, 11'h0A8, '0, '0);
		for (int k = 0; k < 4; k++)
		begin
			second[k] = randomWord();
			addOp(KIND_WRITE, 11'h0A8 + vramAddr_t'(k), second[k], second[k]);
		end
		for (int k = 0; k < 4; k++)
			addOp(KIND_READ, 11'h0A8 + vramAddr_t'(k), '0, second[k]);
		addOp(KIND_READ, 11'h031, '0, first[1]);
	endtask

	// One register write, then wait for the port to go idle
	task automatic cpuAccess(cpuReg_t sel, vramData_t data, inout int fails);
		int waited;
		waited = 0;
		@(posedge CLK_24M);
		cpuSel <= sel;
		cpuWrData <= data;
		cpuWr <= 1'b1;
		@(posedge CLK_24M);
		cpuWr <= 1'b0;
		@(negedge CLK_24M);
		checkLevel("cpuBusy", cpuBusy, 1'b1, fails);
		while (cpuBusy && waited < 64)
		begin
			@(negedge CLK_24M);
			waited++;
		end
		if (cpuBusy)
		begin
			errors++;
			fails++;
			$display("CPU port never went idle, stuck in state %s at %0t ns",
				videoSubsystem_inst.cpuVramPort_inst.state.name(), $time);
		end
	endtask

	task automatic fillRow(vramAddr_t rowBase, inout int fails);
		vramData_t word;
		cpuAccess(1'b0, vramData_t'(rowBase), fails);
		for (int c = 0; c < 40; c++)
		begin
			word = randomWord();
			cpuAccess(1'b1, word, fails);
			model[rowBase + vramAddr_t'(c)] = word;
		end
	endtask

	// Per-clock checks over the measured frame
	task automatic sampleFrame();
		vramAddr_t mapAddr;
		checkCount("hCount", hCount, expCount, frameFails);
		expCount = (expCount == `LINE_LAST) ? '0 : expCount + 1'b1;
		if (hCount == 11'd100)
		begin
			checkLine("vCount", vCount, expLine, frameFails);
			checkLevel("vBlank", vBlank, !(expLine >= 9'h100 && expLine <= 9'h1F0), frameFails);
			checkLevel("nVSync", nVSync, !(expLine >= 9'h0F8 && expLine <= 9'h0FF), frameFails);
			checkLevel("nBnkb", nBnkb, !(expLine >= 9'h1F0 || expLine <= 9'h10F), frameFails);
			// Fix words of the rest of the line belong to this line
			fixLine = expLine;
			fixVisible = (expLine >= 9'h100 && expLine <= 9'h1F0);
			linesSeen++;
			expLine = (expLine == 9'h1FF) ? 9'h0F8 : expLine + 9'd1;
		end
		if (fixStrobe)
		begin
			// Row of 64 words per tile row, one word per column
			mapAddr = `FIX_BASE + vramAddr_t'(fixLine[7:3]) * 11'd64 + vramAddr_t'(fixCol);
			if (!fixVisible)
			begin
				errors++;
				fixFails++;
				$display("Fix strobe seen during vertical blank on line %h at %0t ns",
					fixLine, $time);
			end
			else
				checkWord("fixCode", fixCode, model[mapAddr], fixFails);
			fixCol++;
		end
		if (hCount == `LINE_LAST)
		begin
			if (fixVisible)
				checkCount("fixStrobe pulses", hCount_t'(fixCol), 11'd40, fixFails);
			fixCol = 0;
			if (fixLine == `V_LAST)
			begin
				frameCheck = 1'b0;
				frameDone = 1'b1;
			end
		end
	endtask

	// Outputs sampled mid-cycle
	always @(negedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			syncLen = 0;
			blankLen = 0;
		end
		else
		begin
			// Widths closed at the trailing edge
			if (!nHSync)
				syncLen++;
			else if (syncLen != 0)
			begin
				checkCount("nHSync low clocks", hCount_t'(syncLen), 11'd111, syncFails);
				syncLen = 0;
				syncLines++;
			end
			if (nHBlank)
				blankLen++;
			else if (blankLen != 0)
			begin
				checkCount("nHBlank high clocks", hCount_t'(blankLen), 11'd1280, syncFails);
				blankLen = 0;
				blankLines++;
			end
			// Measured frame opens on the first sync line
			if (armFrame && !frameCheck && !frameDone && hCount == '0 && vCount == `V_FIRST)
			begin
				frameCheck = 1'b1;
				expLine = `V_FIRST;
				fixLine = `V_FIRST;
				fixVisible = 1'b0;
				expCount = '0;
				linesSeen = 0;
				fixCol = 0;
			end
			if (frameCheck)
				sampleFrame();
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_24M);
		$display("Timeout after %0d clocks, the run did not finish", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		int fails;
		vramAddr_t curAddr;
		nRESETP = 1'b0;
		cpuSel = 1'b0;
		cpuWrData = '0;
		cpuWr = 1'b0;
		cpuRd = 1'b0;
		curAddr = '0;
		buildTable();
		repeat (16) @(posedge CLK_24M);
		nRESETP <= 1'b1;
		@(negedge CLK_24M);
		fails = 0;
		checkLine("vCount", vCount, 9'h0F8, fails);
		checkLevel("vBlank", vBlank, 1'b1, fails);
		checkLevel("nVSync", nVSync, 1'b0, fails);
		checkLevel("cpuBusy", cpuBusy, 1'b0, fails);
		$display("reset state: %s", (fails == 0) ? "ok" : "mismatch");
		for (int i = 0; i < OP_COUNT; i++)
		begin
			fails = 0;
			case (opKind[i])
				KIND_LOAD:
				begin
					cpuAccess(1'b0, vramData_t'(opAddr[i]), fails);
					curAddr = opAddr[i];
				end
				KIND_WRITE:
				begin
					cpuAccess(1'b1, opData[i], fails);
					model[curAddr] = opData[i];
					curAddr++;
				end
				KIND_READ:
				begin
					cpuAccess(1'b0, vramData_t'(opAddr[i]), fails);
					curAddr = opAddr[i];
					// Latch loads one clock after busy drops
					@(negedge CLK_24M);
					checkWord("cpuRdData", cpuRdData, opExp[i], fails);
				end
				KIND_FILL:
					fillRow(opAddr[i], fails);
				default:
				begin
					armFrame = 1'b1;
					// Mid-screen of the measured frame
					while (!(frameCheck && vCount == 9'h140 && nHBlank))
						@(negedge CLK_24M);
				end
			endcase
			$display("op %0d kind %0d addr %h: %s", i, opKind[i], opAddr[i],
				(fails == 0) ? "ok" : "mismatch");
		end
		while (!frameDone)
			@(negedge CLK_24M);
		checkCount("lines per frame", hCount_t'(linesSeen), 11'd264, frameFails);
		// At least a full frame of sync pulses and active windows
		if (syncLines < 264 || blankLines < 264)
		begin
			errors++;
			syncFails++;
			$display("Too few lines measured: %0d sync pulses, %0d active windows",
				syncLines, blankLines);
		end
		$display("sync widths: %0d lines, %0d mismatches", syncLines, syncFails);
		$display("frame sequence: %0d lines, %0d mismatches", linesSeen, frameFails);
		$display("fix fetch: %0d mismatches", fixFails);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== verilog/videoSubsystem.sv ====
`timescale 1ns/1ns

module videoSubsystem (
	input logic CLK_24M,
	input logic nRESETP,
	input videoPkg::cpuReg_t cpuSel,
	input videoPkg::vramData_t cpuWrData,
	input logic cpuWr,
	input logic cpuRd,
	output videoPkg::vramData_t cpuRdData,
	output logic cpuBusy,
	output videoPkg::hCount_t hCount,
	output videoPkg::vCount_t vCount,
	output logic nHSync,
	output logic nHBlank,
	output logic vBlank,
	output logic nVSync,
	output logic nBnkb,
	output videoPkg::vramData_t fixCode,
	output logic fixStrobe
);

	import videoPkg::*;

	// Fix fetch side of the RAM
	logic fixReq;
	logic fixValid;
	vramAddr_t fixAddr;
	vramData_t fixData;

	// CPU side of the RAM
	logic cpuReq;
	logic cpuWe;
	logic cpuGnt;
	vramAddr_t cpuAddr;
	vramData_t cpuData;
	vramData_t memRdData;

	videoTiming videoTiming_inst (
		.CLK_24M(CLK_24M), .nRESETP(nRESETP),
		.hCount(hCount), .vCount(vCount), .vBlank(vBlank),
		.nVSync(nVSync), .nHSync(nHSync), .nHBlank(nHBlank), .nBnkb(nBnkb)
	);

	vramController vramController_inst (
		.CLK_24M(CLK_24M), .nRESETP(nRESETP),
		.fixReq(fixReq), .fixAddr(fixAddr), .fixData(fixData), .fixValid(fixValid),
		.cpuReq(cpuReq), .cpuWe(cpuWe), .cpuAddr(cpuAddr), .cpuData(cpuData),
		.cpuGnt(cpuGnt), .memRdData(memRdData)
	);

	fixFetch fixFetch_inst (
		.CLK_24M(CLK_24M), .nRESETP(nRESETP),
		.hCount(hCount), .vCount(vCount), .vBlank(vBlank),
		.fixReq(fixReq), .fixAddr(fixAddr), .fixData(fixData), .fixValid(fixValid),
		.fixCode(fixCode), .fixStrobe(fixStrobe)
	);

	cpuVramPort cpuVramPort_inst (
		.CLK_24M(CLK_24M), .nRESETP(nRESETP),
		.cpuSel(cpuSel), .cpuWrData(cpuWrData), .cpuWr(cpuWr), .cpuRd(cpuRd),
		.cpuRdData(cpuRdData), .cpuBusy(cpuBusy),
		.cpuReq(cpuReq), .cpuWe(cpuWe), .cpuAddr(cpuAddr), .cpuData(cpuData),
		.cpuGnt(cpuGnt), .memRdData(memRdData)
	);

endmodule

// ==== verilog/cpuVramPort.sv ====
`timescale 1ns/1ns

module cpuVramPort (
	input logic CLK_24M,
	input logic nRESETP,
	input videoPkg::cpuReg_t cpuSel,
	input videoPkg::vramData_t cpuWrData,
	input logic cpuWr,
	input logic cpuRd,
	output videoPkg::vramData_t cpuRdData,
	output logic cpuBusy,
	output logic cpuReq,
	output logic cpuWe,
	output videoPkg::vramAddr_t cpuAddr,
	output videoPkg::vramData_t cpuData,
	input logic cpuGnt,
	input videoPkg::vramData_t memRdData
);

	import videoPkg::*;

	portState_t state;
	vramAddr_t addrReg;
	vramData_t wrReg;
	vramData_t rdLatch;
	logic rdStrobe;
	logic accept;

	// Strobes only taken while idle
	assign accept = cpuWr && (state == IDLE);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			state <= IDLE;
			addrReg <= '0;
			rdStrobe <= 1'b0;
		end
		else
		begin
			// Data arrives the clock after a read grant
			rdStrobe <= cpuGnt && (state == READ_PEND);
			case (state)
				IDLE:
					if (accept)
						state <= (cpuSel == 1'b0) ? READ_PEND : WRITE_PEND;
				WRITE_PEND:
					if (cpuGnt)
					begin
						state <= IDLE;
						// Auto-increment for block writes
						addrReg <= addrReg + 1'b1;
					end
				READ_PEND:
					if (cpuGnt)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
			// Address load also triggers the readback
			if (accept && (cpuSel == 1'b0))
				addrReg <= cpuWrData[$bits(vramAddr_t)-1:0];
		end
	end

	// Write data and read latch
	always_ff @(posedge CLK_24M)
	begin
		if (accept && (cpuSel == 1'b1))
			wrReg <= cpuWrData;
		if (rdStrobe)
			rdLatch <= memRdData;
	end

	assign cpuBusy = (state != IDLE);
	assign cpuReq = (state == WRITE_PEND) || (state == READ_PEND);
	assign cpuWe = (state == WRITE_PEND);
	assign cpuAddr = addrReg;
	assign cpuData = wrReg;
	assign cpuRdData = rdLatch;

	// Request held with busy and a steady address until granted
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		cpuReq && !cpuGnt |=> cpuReq && cpuBusy && $stable(cpuAddr))
		else $error("CPU request dropped before grant");

endmodule

// ==== verilog/fixFetch.sv ====
`timescale 1ns/1ns

`include "video_defs.svh"

module fixFetch (
	input logic CLK_24M,
	input logic nRESETP,
	input videoPkg::hCount_t hCount,
	input videoPkg::vCount_t vCount,
	input logic vBlank,
	output logic fixReq,
	output videoPkg::vramAddr_t fixAddr,
	input videoPkg::vramData_t fixData,
	input logic fixValid,
	output videoPkg::vramData_t fixCode,
	output logic fixStrobe
);

	logic lineStart;
	logic fetching;
	logic lastCol;
	logic [5:0] col;
	logic [4:0] pitch;

	// First column slot of the line
	assign lineStart = (hCount == `FIX_FIRST_REQ);
	assign lastCol = (col == `FIX_COLS - 1'b1);

	// Column 0 from the line start, the rest on the pitch
	assign fixReq = lineStart ? !vBlank : (fetching && (pitch == `FIX_PITCH - 1'b1));

	// Map row of 64 words per 8-line tile row
	assign fixAddr = `FIX_BASE + {vCount[7:3], 6'b000000} + {5'b00000, col};

	// Column and pitch scheduling
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			fetching <= 1'b0;
			col <= '0;
			pitch <= '0;
		end
		else
		begin
			// Pitch restarts on every fetch
			if (fixReq)
				pitch <= '0;
			else
				pitch <= pitch + 1'b1;

			// Column returns to 0 after the last one, ready for the next line
			if (fixReq)
			begin
				col <= lastCol ? '0 : col + 1'b1;
				fetching <= !lastCol;
			end
		end
	end

	// Tile word out one clock after the RAM returns it
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			fixStrobe <= 1'b0;
		else
			fixStrobe <= fixValid;
	end

	always_ff @(posedge CLK_24M)
	begin
		if (fixValid)
			fixCode <= fixData;
	end

	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		col < `FIX_COLS)
		else $error("Fix column overrun");

endmodule

// ==== verilog/vramController.sv ====
`timescale 1ns/1ns

`include "video_defs.svh"

module vramController (
	input logic CLK_24M,
	input logic nRESETP,
	input logic fixReq,
	input videoPkg::vramAddr_t fixAddr,
	output videoPkg::vramData_t fixData,
	output logic fixValid,
	input logic cpuReq,
	input logic cpuWe,
	input videoPkg::vramAddr_t cpuAddr,
	input videoPkg::vramData_t cpuData,
	output logic cpuGnt,
	output videoPkg::vramData_t memRdData
);

	import videoPkg::*;

	// 2K words of fix map and CPU-visible storage
	vramData_t mem [0:`VRAM_WORDS-1];

	logic fixGnt;
	vramAddr_t memAddr;
	vramData_t rdWord;

	// Fix fetch always wins the slot
	assign fixGnt = fixReq;
	// CPU only gets the gaps between fix fetches
	assign cpuGnt = cpuReq && !fixReq;

	// Address follows the winner
	assign memAddr = fixGnt ? fixAddr : cpuAddr;

	// Single RAM port
	always_ff @(posedge CLK_24M)
	begin
		if (cpuGnt && cpuWe)
			mem[cpuAddr] <= cpuData;
		rdWord <= mem[memAddr];
	end

	// Fix data valid one clock after the grant
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			fixValid <= 1'b0;
		else
			fixValid <= fixGnt;
	end

	// Same read register feeds both requesters
	assign fixData = rdWord;
	assign memRdData = rdWord;

	// No CPU grant in a fix fetch slot
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		!(fixReq && cpuGnt))
		else $error("CPU granted during fix fetch");

	// Held CPU request waits one clock at most behind a fix fetch
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		cpuReq && !cpuGnt |=> cpuGnt)
		else $error("CPU request starved by fix fetches");

endmodule

// ==== verilog/videoTiming.sv ====
`timescale 1ns/1ns

`include "video_defs.svh"

module videoTiming (
	input logic CLK_24M,
	input logic nRESETP,
	output videoPkg::hCount_t hCount,
	output videoPkg::vCount_t vCount,
	output logic vBlank,
	output logic nVSync,
	output logic nHSync,
	output logic nHBlank,
	output logic nBnkb
);

	logic lineEnd;

	// Last clock of the line
	assign lineEnd = (hCount == `LINE_LAST);

	// Line and frame counters
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			hCount <= '0;
			vCount <= `V_FIRST;
			vBlank <= 1'b1;
		end
		else
		begin
			if (lineEnd)
				hCount <= '0;
			else
				hCount <= hCount + 1'b1;

			if (lineEnd)
			begin
				// Frame wraps back to the sync lines
				if (vCount == `V_LAST)
					vCount <= `V_FIRST;
				else
					vCount <= vCount + 1'b1;

				// Blanking edges fall on the line wrap
				if (vCount == `VBLANK_OFF_LINE)
					vBlank <= 1'b0;
				if (vCount == `VBLANK_ON_LINE)
					vBlank <= 1'b1;
			end
		end
	end

	// Bank strobe, only sampled mid-line
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			nBnkb <= 1'b1;
		else if (hCount == `BNKB_POS)
		begin
			if (vCount == `BNKB_ON_LINE)
				nBnkb <= 1'b0;
			if (vCount == `BNKB_OFF_LINE)
				nBnkb <= 1'b1;
		end
	end

	// Sync low over lines F8 to FF
	assign nVSync = vCount[8];

	// Sync pulse opens the line
	assign nHSync = (hCount > `HSYNC_END);

	// 1280 active clocks
	assign nHBlank = (hCount > `HBLANK_END) && (hCount <= `HACTIVE_END);

	// Line counter wraps before leaving the line
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		hCount <= `LINE_LAST)
		else $error("hCount out of line range");

endmodule

// ==== verilog/videoPkg.sv ====
package videoPkg;

	// Master-clock position within the line, 0 to 1535
	typedef logic [10:0] hCount_t;

	// Line number, F8 to 1FF
	typedef logic [8:0] vCount_t;

	// Video RAM word address and data
	typedef logic [10:0] vramAddr_t;
	typedef logic [15:0] vramData_t;

	// CPU register select
	// 0 is the address register, 1 the data register
	typedef logic cpuReg_t;

	// CPU port sequencer
	typedef enum logic [1:0]
	{
		IDLE,
		WRITE_PEND,
		READ_PEND
	} portState_t;

endpackage

// ==== include/video_defs.svh ====
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Horizontal positions in master clocks, 4 clocks per pixel
`define LINE_LAST 11'd1535
// Last clock of the sync pulse
`define HSYNC_END 11'd110
// Last blank clock before active video
`define HBLANK_END 11'd228
`define HACTIVE_END 11'd1508
// Mid-line point where nBnkb may toggle
`define BNKB_POS 11'd55

// Vertical line numbers
`define V_FIRST 9'h0F8
`define V_LAST 9'h1FF
// Blanking ends after this line
`define VBLANK_OFF_LINE 9'h0FF
// Blanking starts after this line
`define VBLANK_ON_LINE 9'h1F0
`define BNKB_ON_LINE 9'h1F0
`define BNKB_OFF_LINE 9'h110

// Video RAM and fix map
`define VRAM_WORDS 2048
`define FIX_BASE 11'h400
`define FIX_FIRST_REQ 11'd197
`define FIX_COLS 6'd40
`define FIX_PITCH 6'd32

`endif
